// ==== src.f ====
design/branchPkg.sv
design/predictRecordIf.sv
design/predictorTables.sv
design/predictStage.sv
design/creditQueue.sv
design/branchSolve.sv
design/branchUnitTop.sv
bench/branchUnitChecker.sv
bench/branchUnitTb.sv

// ==== bench/branchUnitTb.sv ====
// branch unit testbench
// clock and reset, reference model of the predictor tables,
// directed tests for direction, jumps, training, aliasing, back-pressure
module branchUnitTb;
    timeunit 1ns;
    timeprecision 1ps;
    import branchPkg::*;

    localparam int TBL = 2 ** TABLE_BITS;
    localparam int MAX_CYCLES = 4000; // about 60 records, none needs more than ~30 cycles

    typedef struct packed {
        addrT       pc;
        branchCodeT code;
        logic       isCall;
        wordT       opA;
        wordT       opB;
        addrT       jump;
        addrT       br;
        addrT       pred;   // predicted target at lookup time
    } recT;

    typedef struct packed {
        addrT       pc;
        logic       taken;
        addrT       target;
        branchKindT kind;
        logic       mis;
    } resultT;

    logic clk, rstN, inValid, inIsCall, inCredit, outCredit;
    logic outValid, outTaken, outMispredict;
    addrT inPc, inJumpAddr, inBranchAddr, outPc, outTarget;
    wordT inOperandA, inOperandB;
    branchCodeT inCode;
    branchKindT outKind;

    logic [1:0] mCount [TBL];
    logic       mValid [TBL];
    addrT       mTag [TBL];
    addrT       mTarget [TBL];
    recT        pending [$];
    resultT     results [$];
    int         inCredits = QUEUE_DEPTH;
    int         cycles = 0;
    int         seed = 27350;
    logic       lastMis;

    branchUnitTop #(
        .tableBits(TABLE_BITS), .queueDepth(QUEUE_DEPTH), .outCredits(OUT_CREDITS)
    ) branchUnitTop_i (.*);

    always #50 clk = ~clk;

    // credit returns, results and timeout
    always @(posedge clk) begin
        if (rstN) begin
            cycles++;
            if (inCredit) inCredits++;
            if (outValid) results.push_back('{outPc, outTaken, outTarget, outKind, outMispredict});
            if (cycles >= MAX_CYCLES) begin
                $display("timeout after %0d cycles waiting for the DUT", cycles);
                $display("test failed");
                $fatal(1, "timeout");
            end
        end
    end

    task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp);
            $display("test failed");
            $fatal(1, "value mismatch");
        end
    endtask

    // actual outcome from the branch rules
    function automatic void resolveRef(input recT r, output logic taken, output addrT target,
                                       output branchKindT kind);
        taken = 1'b0;
        kind  = kindImme;
        case (r.code)
            codeBeq:  taken = (r.opA == r.opB);
            codeBne:  taken = (r.opA != r.opB);
            codeBgez: taken = ($signed(r.opA) >= 0);
            codeBgtz: taken = ($signed(r.opA) > 0);
            codeBlez: taken = ($signed(r.opA) <= 0);
            codeBltz: taken = ($signed(r.opA) < 0);
            codeJ: begin
                taken = 1'b1;
                kind  = r.isCall ? kindCall : kindImme;
            end
            codeJr: begin
                taken = 1'b1;
                kind  = r.isCall ? kindCall : kindRetn;
            end
            default:  kind = kindNone;
        endcase
        if (r.code == codeJ) target = r.jump;
        else if (r.code == codeJr) target = r.opA;
        else target = taken ? r.br : r.pc + 32'd8;
    endfunction

    task automatic sendRecord(input addrT pc, input branchCodeT code, input logic isCall,
                              input wordT a, input wordT b, input addrT jump, input addrT br);
        recT r;
        int  idx;
        while (inCredits == 0) @(negedge clk);
        idx = pc[2 +: TABLE_BITS];
        r = '{pc, code, isCall, a, b, jump, br, pc + 32'd8};
        if (code != codeNone && mValid[idx] && mTag[idx] == (pc >> (2 + TABLE_BITS))
            && mCount[idx][1]) r.pred = mTarget[idx];
        pending.push_back(r);
        inValid      = 1'b1;
        inPc         = pc;
        inCode       = code;
        inIsCall     = isCall;
        inOperandA   = a;
        inOperandB   = b;
        inJumpAddr   = jump;
        inBranchAddr = br;
        inCredits--;
        @(negedge clk);
        inValid = 1'b0;
    endtask

    // takes the oldest result, returns its credit, updates the model
    task automatic checkNext();
        recT        r;
        resultT     res;
        logic       taken;
        addrT       target;
        branchKindT kind;
        int         idx;
        while (results.size() == 0) @(negedge clk);
        if (pending.size() == 0) begin
            $display("a result appeared with no record outstanding");
            $display("test failed");
            $fatal(1, "unexpected result");
        end
        res = results.pop_front();
        r   = pending.pop_front();
        outCredit = 1'b1;
        @(negedge clk);
        outCredit = 1'b0;
        resolveRef(r, taken, target, kind);
        checkValue("outPc", res.pc, r.pc);
        checkValue("outTaken", res.taken, taken);
        checkValue("outTarget", res.target, target);
        checkValue("outKind", res.kind, kind);
        checkValue("outMispredict", res.mis, r.pred != target);
        lastMis = res.mis;
        idx = r.pc[2 +: TABLE_BITS];
        if (kind != kindNone) begin
            if (taken) begin
                if (mCount[idx] != 2'd3) mCount[idx]++;
                mValid[idx]  = 1'b1;
                mTag[idx]    = r.pc >> (2 + TABLE_BITS);
                mTarget[idx] = target;
            end else if (mCount[idx] != 2'd0) begin
                mCount[idx]--;
            end
        end
    endtask

    task automatic runOne(input addrT pc, input branchCodeT code, input logic isCall,
                          input wordT a, input wordT b, input addrT jump, input addrT br);
        sendRecord(pc, code, isCall, a, b, jump, br);
        checkNext();
    endtask

    task automatic testDirection();
        wordT a [6];
        wordT b [6];
        addrT pc;
        a = '{32'h0, 32'hffff_fff0, 32'h8000_0000, 32'h5, wordT'($random(seed)), 32'h1};
        b = '{32'h0, 32'hffff_fff0, 32'h0, 32'h7, wordT'($random(seed)), 32'h0};
        a[5] = $random(seed);
        b[5] = a[5]; // equal random pair
        for (int c = 0; c < 6; c++) begin
            for (int k = 0; k < 6; k++) begin
                pc = 32'h0040_0000 + (c * 6 + k) * 4; // indices 0 to 35
                runOne(pc, branchCodeT'(int'(codeBeq) + c), 1'b0, a[k], b[k], 32'h0, pc + 32'h100);
            end
        end
    endtask

    task automatic testJumps();
        runOne(32'h0040_00a0, codeJ, 1'b0, $random(seed), 32'h0, 32'h0041_0000, 32'h0);
        runOne(32'h0040_00a4, codeJ, 1'b1, $random(seed), 32'h0, 32'h0042_0000, 32'h0);
        runOne(32'h0040_00a8, codeJr, 1'b0, 32'h0043_1230, 32'h0, 32'h0044_0000, 32'h0);
        runOne(32'h0040_00ac, codeJr, 1'b1, 32'h0045_5670, 32'h0, 32'h0046_0000, 32'h0);
    endtask

    task automatic testTraining();
        addrT pc = 32'h0040_00c8; // index 50, cold
        addrT br = 32'h0040_0400;
        sendRecord(pc, codeBeq, 1'b0, 32'h7, 32'h7, 32'h0, br);
        sendRecord(pc, codeBeq, 1'b0, 32'h7, 32'h7, 32'h0, br); // looks up before first update
        checkNext();
        checkValue("outMispredict", lastMis, 1'b1);
        checkNext();
        checkValue("outMispredict", lastMis, 1'b1);
        runOne(pc, codeBeq, 1'b0, 32'h7, 32'h7, 32'h0, br);
        checkValue("outMispredict", lastMis, 1'b0);
        runOne(pc, codeBeq, 1'b0, 32'h7, 32'h8, 32'h0, br);
        checkValue("outMispredict", lastMis, 1'b1);
    endtask

    task automatic testAliasing();
        addrT pcA = 32'h0040_00d0; // index 52
        addrT pcB = 32'h0040_01d0; // same index, other tag
        addrT tgt = 32'h0050_0000;
        runOne(pcA, codeBeq, 1'b0, 32'h1, 32'h1, 32'h0, tgt);
        runOne(pcA, codeBeq, 1'b0, 32'h1, 32'h1, 32'h0, tgt);
        runOne(pcB, codeBeq, 1'b0, 32'h1, 32'h1, 32'h0, tgt); // a false hit would predict tgt
        checkValue("outMispredict", lastMis, 1'b1);
    endtask

    task automatic testBackPressure();
        addrT pc;
        for (int k = 0; k < QUEUE_DEPTH + OUT_CREDITS; k++) begin
            pc = 32'h0040_00e0 + k * 4; // indices 56 up
            sendRecord(pc, codeBne, 1'b0, $random(seed), $random(seed), 32'h0, pc + 32'h200);
        end
        repeat (20) @(negedge clk);
        checkValue("inCredit count", inCredits, 0);
        checkValue("outValid count", results.size(), OUT_CREDITS);
        for (int k = 0; k < QUEUE_DEPTH + OUT_CREDITS; k++) checkNext();
    endtask

    task automatic testNonBranch();
        for (int k = 0; k < 4; k++) begin
            runOne(32'h0040_00b0 + k * 4, codeNone, 1'b0, $random(seed), $random(seed),
                   $random(seed), $random(seed));
            checkValue("outMispredict", lastMis, 1'b0);
        end
    endtask

    initial begin
        clk          = 1'b0;
        rstN         = 1'b0;
        inValid      = 1'b0;
        inPc         = '0;
        inCode       = codeNone;
        inIsCall     = 1'b0;
        inOperandA   = '0;
        inOperandB   = '0;
        inJumpAddr   = '0;
        inBranchAddr = '0;
        outCredit    = 1'b0;
        for (int i = 0; i < TBL; i++) begin
            mCount[i]  = 2'd1;
            mValid[i]  = 1'b0;
            mTag[i]    = '0;
            mTarget[i] = '0;
        end
        repeat (8) @(negedge clk);
        rstN = 1'b1;
        testDirection();
        testJumps();
        testTraining();
        testAliasing();
        testBackPressure();
        testNonBranch();
        if (pending.size() != 0 || results.size() != 0) begin
            $display("records left unresolved at the end of the run");
            $display("test failed");
            $fatal(1, "unresolved records");
        end else begin
            $display("test passed");
            $finish;
        end
    end

endmodule

// ==== bench/branchUnitChecker.sv ====
// concurrent assertions for the branch unit
// queue overflow, output credit accounting, output validity
// bound into creditQueue and branchSolve
module branchUnitChecker #(
    parameter int maxCredits = 1
) (
    input logic clk,
    input logic rstN,
    input logic wrValid,
    input logic queueFull,
    input int   credits,
    input logic outValid,
    input logic outMispredict
);
    timeunit 1ns;
    timeprecision 1ps;

    // sender credits keep the queue from overrunning
    noFullWrite: assert property (@(posedge clk) disable iff (!rstN)
        !(wrValid && queueFull)) else $error("write into a full queue");

    creditBound: assert property (@(posedge clk) disable iff (!rstN)
        credits <= maxCredits) else $error("more output credits than issued");

    // each result spends a credit held at the pop edge
    creditHeld: assert property (@(posedge clk) disable iff (!rstN)
        outValid |-> $past(credits) > 0) else $error("result sent without a credit");

    resetQuiet: assert property (@(posedge clk)
        !rstN |-> !outValid) else $error("outValid high during reset");

    misWithValid: assert property (@(posedge clk) disable iff (!rstN)
        $rose(outMispredict) |-> outValid) else $error("mispredict raised without outValid");

endmodule

bind creditQueue branchUnitChecker queueChecker (
    .clk, .rstN, .wrValid(wr.valid), .queueFull(fill == queueDepth),
    .credits(0), .outValid(1'b0), .outMispredict(1'b0)
);

bind branchSolve branchUnitChecker #(.maxCredits(outCredits)) solveChecker (
    .clk, .rstN, .wrValid(1'b0), .queueFull(1'b0), .credits(creditCnt),
    .outValid, .outMispredict
);

// ==== design/branchUnitTop.sv ====
// branch unit top level
// predict stage, credit queue and resolve stage around the predictor tables
module branchUnitTop #(
    parameter int tableBits  = branchPkg::TABLE_BITS,
    parameter int queueDepth = branchPkg::QUEUE_DEPTH,
    parameter int outCredits = branchPkg::OUT_CREDITS
) (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  inValid,
    input  branchPkg::addrT       inPc,
    input  branchPkg::branchCodeT inCode,
    input  logic                  inIsCall,
    input  branchPkg::wordT       inOperandA,
    input  branchPkg::wordT       inOperandB,
    input  branchPkg::addrT       inJumpAddr,
    input  branchPkg::addrT       inBranchAddr,
    output logic                  inCredit,
    input  logic                  outCredit,
    output logic                  outValid,
    output branchPkg::addrT       outPc,
    output logic                  outTaken,
    output branchPkg::addrT       outTarget,
    output branchPkg::branchKindT outKind,
    output logic                  outMispredict
);
    import branchPkg::*;

    addrT lookupPc;
    logic lookupTaken;
    addrT lookupTarget;
    logic lookupHit;
    logic pop;

    predictRecordIf stageRec ();  // predict stage into queue
    predictRecordIf headRec ();   // queue head into resolve
    tableUpdateIf   tableUpd ();

    predictorTables #(.tableBits(tableBits)) predictorTables_i (
        .clk, .rstN, .lookupPc, .lookupTaken, .lookupTarget, .lookupHit,
        .update(tableUpd.dst)
    );

    predictStage predictStage_i (
        .clk, .rstN, .inValid, .inPc, .inCode, .inIsCall, .inOperandA,
        .inOperandB, .inJumpAddr, .inBranchAddr, .lookupPc, .lookupTaken,
        .lookupTarget, .lookupHit, .rec(stageRec.src)
    );

    creditQueue #(.queueDepth(queueDepth)) creditQueue_i (
        .clk, .rstN, .wr(stageRec.dst), .rd(headRec.src), .pop, .inCredit
    );

    branchSolve #(.outCredits(outCredits)) branchSolve_i (
        .clk, .rstN, .rec(headRec.dst), .pop, .outCredit,
        .update(tableUpd.src), .outValid, .outPc, .outTaken, .outTarget,
        .outKind, .outMispredict
    );

endmodule

// ==== design/branchSolve.sv ====
// branch resolve stage
// computes actual direction, target and kind of the head record,
// flags mispredictions and writes the outcome back to the tables
// output side is credit controlled
module branchSolve #(
    parameter int outCredits = branchPkg::OUT_CREDITS
) (
    input  logic                  clk,
    input  logic                  rstN,
    predictRecordIf.dst           rec,
    output logic                  pop,
    input  logic                  outCredit,
    tableUpdateIf.src             update,
    output logic                  outValid,
    output branchPkg::addrT       outPc,
    output logic                  outTaken,
    output branchPkg::addrT       outTarget,
    output branchPkg::branchKindT outKind,
    output logic                  outMispredict
);
    import branchPkg::*;

    localparam int creditBits = $clog2(outCredits + 1);

    typedef logic [creditBits-1:0] creditT;

    creditT     creditCnt;
    logic       opEqual;
    logic       opNegative;
    logic       opZero;
    logic       actTaken;
    addrT       actTarget;
    branchKindT actKind;
    addrT       seqPc;
    logic       mispredict;

    // operand tests
    assign opEqual    = (rec.operandA == rec.operandB);
    assign opNegative = rec.operandA[WORD_WIDTH-1];
    assign opZero     = (rec.operandA == '0);
    assign seqPc      = rec.pc + SEQ_OFFSET;

    always_comb begin
        actTaken  = 1'b0;
        actTarget = seqPc;
        actKind   = kindImme;
        case (rec.code)
            codeBeq:  actTaken = opEqual;
            codeBne:  actTaken = !opEqual;
            codeBgez: actTaken = !opNegative;
            codeBgtz: actTaken = !opNegative && !opZero;
            codeBlez: actTaken = opNegative || opZero;
            codeBltz: actTaken = opNegative;
            codeJ: begin
                actTaken = 1'b1;
                actKind  = rec.isCall ? kindCall : kindImme;
            end
            codeJr: begin
                actTaken = 1'b1;
                actKind  = rec.isCall ? kindCall : kindRetn;
            end
            default:  actKind = kindNone; // not a branch
        endcase

        if (rec.code == codeJ) begin
            actTarget = rec.jumpAddr;
        end else if (rec.code == codeJr) begin
            actTarget = rec.operandA; // register target
        end else if (actTaken) begin
            actTarget = rec.branchAddr;
        end
    end

    // direction is implied by the target, so compare targets only
    assign mispredict = (rec.predTarget != actTarget);

    assign pop = rec.valid && (creditCnt != '0);

    // update lands on the same edge as the registered result
    assign update.valid  = pop;
    assign update.pc     = rec.pc;
    assign update.taken  = actTaken;
    assign update.target = actTarget;
    assign update.kind   = actKind;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            creditCnt <= creditT'(outCredits);
            outValid  <= 1'b0;
        end else begin
            creditCnt <= creditCnt - creditT'(pop) + creditT'(outCredit);
            outValid  <= pop;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            outPc         <= rec.pc;
            outTaken      <= actTaken;
            outTarget     <= actTarget;
            outKind       <= actKind;
            outMispredict <= mispredict;
        end
    end

endmodule

// ==== design/creditQueue.sv ====
// first-word-fall-through record queue
// circular buffer with fill count, one credit pulse per pop
module creditQueue #(
    parameter int queueDepth = branchPkg::QUEUE_DEPTH
) (
    input  logic        clk,
    input  logic        rstN,
    predictRecordIf.dst wr,
    predictRecordIf.src rd,
    input  logic        pop,
    output logic        inCredit
);
    import branchPkg::*;

    localparam int ptrBits = (queueDepth > 1) ? $clog2(queueDepth) : 1;
    localparam int cntBits = $clog2(queueDepth + 1);

    typedef logic [ptrBits-1:0] ptrT;
    typedef logic [cntBits-1:0] cntT;

    typedef struct packed {
        addrT       pc;
        branchCodeT code;
        logic       isCall;
        wordT       operandA;
        wordT       operandB;
        addrT       jumpAddr;
        addrT       branchAddr;
        logic       predTaken;
        addrT       predTarget;
        logic       hit;
    } entryT;

    entryT mem [queueDepth];
    entryT wrEntry;
    entryT head;
    ptrT   wrPtr;
    ptrT   rdPtr;
    cntT   fill;
    logic  doPop;

    function automatic ptrT nextPtr(input ptrT p);
        return (p == ptrT'(queueDepth - 1)) ? '0 : p + 1'b1;
    endfunction

    assign wrEntry = '{pc: wr.pc, code: wr.code, isCall: wr.isCall,
                       operandA: wr.operandA, operandB: wr.operandB,
                       jumpAddr: wr.jumpAddr, branchAddr: wr.branchAddr,
                       predTaken: wr.predTaken, predTarget: wr.predTarget,
                       hit: wr.hit};

    assign doPop = pop && (fill != '0); // pop on empty is ignored
    assign head  = mem[rdPtr];

    assign rd.valid      = (fill != '0);
    assign rd.pc         = head.pc;
    assign rd.code       = head.code;
    assign rd.isCall     = head.isCall;
    assign rd.operandA   = head.operandA;
    assign rd.operandB   = head.operandB;
    assign rd.jumpAddr   = head.jumpAddr;
    assign rd.branchAddr = head.branchAddr;
    assign rd.predTaken  = head.predTaken;
    assign rd.predTarget = head.predTarget;
    assign rd.hit        = head.hit;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            wrPtr    <= '0;
            rdPtr    <= '0;
            fill     <= '0;
            inCredit <= 1'b0;
        end else begin
            if (wr.valid) wrPtr <= nextPtr(wrPtr);
            if (doPop) rdPtr <= nextPtr(rdPtr);
            fill     <= fill + cntT'(wr.valid) - cntT'(doPop);
            inCredit <= doPop; // one slot freed upstream
        end
    end

    always_ff @(posedge clk) begin
        if (wr.valid) mem[wrPtr] <= wrEntry;
    end

endmodule

// ==== design/predictStage.sv ====
// predict stage
// looks the incoming pc up in the predictor tables and
// registers the record together with its prediction
module predictStage (
    input  logic                  clk,
    input  logic                  rstN,
    input  logic                  inValid,
    input  branchPkg::addrT       inPc,
    input  branchPkg::branchCodeT inCode,
    input  logic                  inIsCall,
    input  branchPkg::wordT       inOperandA,
    input  branchPkg::wordT       inOperandB,
    input  branchPkg::addrT       inJumpAddr,
    input  branchPkg::addrT       inBranchAddr,
    output branchPkg::addrT       lookupPc,
    input  logic                  lookupTaken,
    input  branchPkg::addrT       lookupTarget,
    input  logic                  lookupHit,
    predictRecordIf.src           rec
);
    import branchPkg::*;

    logic isBranch;
    logic predTaken;
    addrT predTarget;

    assign lookupPc = inPc;

    // non-branch never predicts taken
    assign isBranch   = (inCode != codeNone);
    assign predTaken  = isBranch && lookupTaken;
    assign predTarget = predTaken ? lookupTarget : inPc + SEQ_OFFSET;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            rec.valid <= 1'b0;
        end else begin
            rec.valid <= inValid;
        end
    end

    // payload only loads with a valid record
    always_ff @(posedge clk) begin
        if (inValid) begin
            rec.pc         <= inPc;
            rec.code       <= inCode;
            rec.isCall     <= inIsCall;
            rec.operandA   <= inOperandA;
            rec.operandB   <= inOperandB;
            rec.jumpAddr   <= inJumpAddr;
            rec.branchAddr <= inBranchAddr;
            rec.predTaken  <= predTaken;
            rec.predTarget <= predTarget;
            rec.hit        <= lookupHit;
        end
    end

endmodule

// ==== design/predictorTables.sv ====
// bimodal history table of 2-bit counters
// direct-mapped branch target buffer with tag and valid bit
// one combinational lookup port, one clocked update port
module predictorTables #(
    parameter int tableBits = branchPkg::TABLE_BITS
) (
    input  logic            clk,
    input  logic            rstN,
    input  branchPkg::addrT lookupPc,
    output logic            lookupTaken,
    output branchPkg::addrT lookupTarget,
    output logic            lookupHit,
    tableUpdateIf.dst       update
);
    import branchPkg::*;

    localparam int entries = 2 ** tableBits;
    localparam int tagBits = ADDR_WIDTH - INDEX_LSB - tableBits;

    typedef logic [tableBits-1:0] indexT;
    typedef logic [tagBits-1:0]   tagT;

    counterT            counters [entries];
    logic [entries-1:0] entryValid;
    tagT                tags [entries];
    addrT               targets [entries];

    indexT   lookupIdx;
    tagT     lookupTag;
    indexT   updateIdx;
    tagT     updateTag;
    counterT updateCount;
    logic    updateEn;

    assign lookupIdx = lookupPc[INDEX_LSB +: tableBits];
    assign lookupTag = lookupPc[ADDR_WIDTH-1 -: tagBits];
    assign updateIdx = update.pc[INDEX_LSB +: tableBits];
    assign updateTag = update.pc[ADDR_WIDTH-1 -: tagBits];

    // non-branch records leave the tables alone
    assign updateEn    = update.valid && (update.kind != kindNone);
    assign updateCount = counters[updateIdx];

    assign lookupHit    = entryValid[lookupIdx] && (tags[lookupIdx] == lookupTag);
    assign lookupTaken  = counters[lookupIdx][COUNTER_BITS-1] && lookupHit;
    assign lookupTarget = targets[lookupIdx];

    // counters and valid bits
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < entries; i++) begin
                counters[i] <= COUNTER_INIT; // weakly not taken
            end
            entryValid <= '0;
        end else if (updateEn) begin
            if (update.taken) begin
                if (updateCount != COUNTER_MAX) begin
                    counters[updateIdx] <= updateCount + 1'b1;
                end
                entryValid[updateIdx] <= 1'b1;
            end else if (updateCount != '0) begin
                counters[updateIdx] <= updateCount - 1'b1;
            end
        end
    end

    // target and tag follow taken outcomes only
    always_ff @(posedge clk) begin
        if (updateEn && update.taken) begin
            targets[updateIdx] <= update.target;
            tags[updateIdx]    <= updateTag;
        end
    end

endmodule

// ==== design/predictRecordIf.sv ====
// predictRecordIf: branch record with its prediction
// tableUpdateIf: resolved outcome written back to the predictor
interface predictRecordIf;
    import branchPkg::*;

    logic       valid;
    addrT       pc;
    branchCodeT code;
    logic       isCall;
    wordT       operandA;
    wordT       operandB;
    addrT       jumpAddr;
    addrT       branchAddr;
    logic       predTaken;
    addrT       predTarget;
    logic       hit;        // target buffer hit at lookup

    modport src (output valid, pc, code, isCall, operandA, operandB, jumpAddr,
                 branchAddr, predTaken, predTarget, hit);
    modport dst (input valid, pc, code, isCall, operandA, operandB, jumpAddr,
                 branchAddr, predTaken, predTarget, hit);
endinterface

interface tableUpdateIf;
    import branchPkg::*;

    logic       valid;
    addrT       pc;
    logic       taken;
    addrT       target;
    branchKindT kind;

    modport src (output valid, pc, taken, target, kind);
    modport dst (input valid, pc, taken, target, kind);
endinterface

// ==== design/branchPkg.sv ====
// shared widths and types for the branch unit
// branch codes, branch kinds, history counter encoding
// default sizes for tables, queue and output credits
package branchPkg;

    localparam int ADDR_WIDTH   = 32;
    localparam int WORD_WIDTH   = 32;
    localparam int COUNTER_BITS = 2;

    typedef logic [ADDR_WIDTH-1:0]   addrT;    // pc or target
    typedef logic [WORD_WIDTH-1:0]   wordT;    // register operand
    typedef logic [COUNTER_BITS-1:0] counterT; // bimodal counter

    // 0,1 predict not taken; 2,3 predict taken
    localparam counterT COUNTER_INIT = counterT'(1);
    localparam counterT COUNTER_MAX  = counterT'(3);

    // word aligned pc, index starts above the byte offset
    localparam int INDEX_LSB = 2;

    // fall-through address skips the delay slot
    localparam addrT SEQ_OFFSET = addrT'(8);

    // default sizes, overridden from the top level
    localparam int TABLE_BITS  = 6;
    localparam int QUEUE_DEPTH = 4;
    localparam int OUT_CREDITS = 2;

    typedef enum logic [3:0] {
        codeNone,   // not a branch
        codeBeq,
        codeBne,
        codeBgez,
        codeBgtz,
        codeBlez,
        codeBltz,
        codeJ,
        codeJr
    } branchCodeT;

    // kind reported back to the predictor
    typedef enum logic [1:0] {
        kindNone,
        kindImme,   // conditional branch or plain J
        kindCall,   // J or JR with link
        kindRetn    // JR without link
    } branchKindT;

endpackage
